/* Makefile */
# Verilator build of the simpleton testbench
BIN  := obj_dir/Vsimpleton_tb
SRCS := $(wildcard rtl/*.sv bench/*.sv include/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): files.f $(SRCS)
	verilator --binary --timing -j 0 --top-module simpleton_tb -f files.f

# exit status of the binary is the test verdict
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

/* include/simpleton_model.svh */
`ifndef SIMPLETON_MODEL_SVH
`define SIMPLETON_MODEL_SVH

// model word width follows the package default
localparam int MODEL_W     = simpleton_pkg::DATA_W_DEFAULT;
localparam int MODEL_DEPTH = 1 << MODEL_W;
localparam int MODEL_LOW_W = MODEL_W - simpleton_pkg::OPC_W;

typedef logic [MODEL_W-1:0] model_mem_t [MODEL_DEPTH];

// one LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// instruction-set model, counts the halting opcode as an instruction
function automatic void run_model(input model_mem_t image, output model_mem_t final_mem,
                                  output logic [MODEL_W-1:0] acc,
                                  output logic [MODEL_W-1:0] pc, output int count);
    logic [MODEL_W-1:0]              opc_word;
    logic [simpleton_pkg::OPC_W-1:0] opc;
    logic [MODEL_W-1:0]              adr;
    bit                              done;
    final_mem = image;
    acc       = '0;
    pc        = '0;
    count     = 0;
    done      = 1'b0;
    // bounded in case a program never reaches a halt
    while (!done && count < MODEL_DEPTH) begin
        opc_word = final_mem[pc];
        opc      = opc_word[MODEL_W-1 -: simpleton_pkg::OPC_W];
        pc       = pc + 1'b1;
        count++;
        // only LDA, ADD and STA carry an operand word, anything else stops
        if (opc != simpleton_pkg::OPC_LDA && opc != simpleton_pkg::OPC_ADD &&
            opc != simpleton_pkg::OPC_STA) begin
            done = 1'b1;
        end else begin
            adr = final_mem[pc];
            pc  = pc + 1'b1;
            case (opc)
                simpleton_pkg::OPC_LDA: acc = final_mem[adr];
                simpleton_pkg::OPC_ADD: acc = acc + final_mem[adr];
                default:                final_mem[adr] = acc;
            endcase
        end
    end
endfunction

// random program in the lower half, random data in the upper half
function automatic void gen_program(inout logic [31:0] seed, output model_mem_t image);
    int                     n_instr;
    simpleton_pkg::opcode_t opc;
    for (int i = 0; i < MODEL_DEPTH; i++) begin
        seed     = lcg_next(seed);
        image[i] = (i < MODEL_DEPTH / 2) ? '0 : seed[23 -: MODEL_W];
    end
    seed    = lcg_next(seed);
    n_instr = 1 + int'(seed[31:16] % 12);
    for (int k = 0; k < n_instr; k++) begin
        seed = lcg_next(seed);
        case (seed[31:16] % 3)
            0:       opc = simpleton_pkg::OPC_LDA;
            1:       opc = simpleton_pkg::OPC_ADD;
            default: opc = simpleton_pkg::OPC_STA;
        endcase
        // low nibble of the opcode word is noise the core must ignore
        image[2*k]     = {opc, seed[MODEL_LOW_W-1:0]};
        image[2*k + 1] = MODEL_W'(MODEL_DEPTH / 2 + int'(seed[15:8]) % (MODEL_DEPTH / 2));
    end
    image[2*n_instr] = {simpleton_pkg::OPC_HLT, MODEL_LOW_W'(0)};
endfunction

`endif

/* bench/simpleton_tb.sv */
`timescale 1ns/1ps

module simpleton_tb;

    import simpleton_pkg::*;

    `include "simpleton_model.svh"

    localparam int DATA_W    = 8;
    // data half of memory, where every program keeps its operands
    localparam int DATA_BASE = MODEL_DEPTH / 2;
    // opcodes with no defined meaning
    localparam logic [3:0] BAD_OPC [2] = '{4'h0, 4'h9};

    logic              clk;
    logic              rst;
    logic              run;
    logic              load_we;
    logic [DATA_W-1:0] load_addr;
    logic [DATA_W-1:0] load_wdata;
    logic [DATA_W-1:0] load_rdata;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] pc;
    logic              halted;

    // cycles spent with run high, and the budget summed over the tests so far
    int          run_cycles;
    int          cycle_limit;
    logic [31:0] seed;

    simpleton_top #(
        .DATA_W (DATA_W)
    ) i_simpleton_top (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_wdata (load_wdata),
        .load_rdata (load_rdata),
        .acc        (acc),
        .pc         (pc),
        .halted     (halted)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // watchdog, only the run phase can hang
    always @(posedge clk) begin
        if (run) begin
            run_cycles++;
            if (run_cycles > cycle_limit) begin
                $display("Test failures found");
                $fatal(1, "timeout: the core did not halt within %0d run cycles", cycle_limit);
            end
        end
    end

    // one clock, landing 1 ns after the edge where inputs change and outputs are settled
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
            $display("Test failures found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) next_cycle();
        rst = 1'b0;
    endtask

    // background image, every word tied to its own address
    function automatic void fill_image(output model_mem_t img);
        for (int a = 0; a < MODEL_DEPTH; a++) begin
            img[a] = MODEL_W'(a) ^ 8'h5a;
        end
    endfunction

    // one word per cycle through the load port
    task automatic load_image(input model_mem_t img);
        for (int a = 0; a < MODEL_DEPTH; a++) begin
            load_we    = 1'b1;
            load_addr  = DATA_W'(a);
            load_wdata = img[a];
            next_cycle();
        end
        load_we = 1'b0;
    endtask

    // load, reset, run to halt, then compare against the ISA model
    task automatic execute_and_check(input string tag, input model_mem_t img);
        model_mem_t         exp_mem;
        logic [MODEL_W-1:0] exp_acc;
        logic [MODEL_W-1:0] exp_pc;
        int                 n_instr;
        run_model(img, exp_mem, exp_acc, exp_pc, n_instr);
        cycle_limit += 6 * n_instr + 50;
        load_image(img);
        apply_reset();
        run = 1'b1;
        while (halted !== 1'b1) begin
            next_cycle();
        end
        run = 1'b0;
        check_value({tag, " acc"}, 32'(acc), 32'(exp_acc));
        check_value({tag, " pc"}, 32'(pc), 32'(exp_pc));
        // whole data half, stored words included
        for (int a = DATA_BASE; a < MODEL_DEPTH; a++) begin
            next_cycle();
            load_addr = DATA_W'(a);
            #1;
            check_value($sformatf("%s mem[%0h]", tag, a), 32'(load_rdata),
                        32'(exp_mem[a]));
        end
    endtask

    initial begin
        model_mem_t prog;
        clk         = 1'b0;
        rst         = 1'b1;
        run         = 1'b0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_wdata  = '0;
        run_cycles  = 0;
        cycle_limit = 0;
        seed        = 32'hc699;
        repeat (5) next_cycle();
        rst = 1'b0;

        // idle core with run low
        repeat (20) next_cycle();
        check_value("halted", 32'(halted), 32'd0);
        check_value("acc", 32'(acc), 32'd0);
        check_value("pc", 32'(pc), 32'd0);

        // LDA, ADD, STA, HLT on upper-half data
        fill_image(prog);
        prog[0]     = {OPC_LDA, 4'h0};
        prog[1]     = 8'h80;
        prog[2]     = {OPC_ADD, 4'h0};
        prog[3]     = 8'h81;
        prog[4]     = {OPC_STA, 4'h0};
        prog[5]     = 8'h82;
        prog[6]     = {OPC_HLT, 4'h0};
        prog[8'h80] = 8'h25;
        prog[8'h81] = 8'h13;
        execute_and_check("fixed", prog);

        // sum above 255 wraps
        prog[5]     = 8'h83;
        prog[8'h80] = 8'hc8;
        prog[8'h81] = 8'h64;
        execute_and_check("wrap", prog);
        check_value("wrap acc", 32'(acc), (32'hc8 + 32'h64) % 32'd256);

        // undefined opcode at address 4 stops the core
        for (int k = 0; k < 2; k++) begin
            fill_image(prog);
            prog[0] = {OPC_LDA, 4'h3};
            prog[1] = 8'h90;
            prog[2] = {OPC_ADD, 4'h0};
            prog[3] = 8'h91;
            prog[4] = {BAD_OPC[k], 4'h7};
            execute_and_check($sformatf("undef %0h", BAD_OPC[k]), prog);
            check_value("undef pc", 32'(pc), 32'd5);
            check_value("undef acc", 32'(acc), 32'(MODEL_W'(prog[8'h90] + prog[8'h91])));
        end

        // random programs from the LCG
        for (int p = 0; p < 10; p++) begin
            gen_program(seed, prog);
            execute_and_check($sformatf("random %0d", p), prog);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* files.f */
+incdir+include
rtl/simpleton_pkg.sv
rtl/simpleton_datapath.sv
rtl/simpleton_control.sv
rtl/simpleton_memory.sv
rtl/simpleton_top.sv
bench/simpleton_tb.sv

/* rtl/simpleton_control.sv */
`timescale 1ns/1ps

module simpleton_control (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            run,

    // bus slave response
    input  logic                            wb_ack,
    // upper bits of the read data word
    input  logic [simpleton_pkg::OPC_W-1:0] wb_opcode,

    // bus master strobes
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,

    // datapath controls
    output logic                            pc_inc,
    output logic                            adr_load,
    output logic                            acc_load,
    output logic                            acc_add,
    output logic                            adr_sel_pc,

    // status
    output logic                            halted
);

    import simpleton_pkg::*;

    state_t state_q;
    state_t state_d;

    // instruction latched at the opcode fetch
    instr_t instr_q;
    // decode of the word on the bus right now
    instr_t instr_dec;

    // bus access in flight
    logic   busy;
    logic   is_fetch;

    assign instr_dec = decode_opcode(wb_opcode);

    // state register
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // instruction register
    // only captured when the opcode read is acknowledged
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_q <= INS_HLT;
        end else if (state_q == ST_FETCH_OP && wb_ack) begin
            instr_q <= instr_dec;
        end
    end

    // next state
    // every bus state waits for ack before moving on
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (run) begin
                    state_d = ST_FETCH_OP;
                end
            end
            ST_FETCH_OP: begin
                // halt decided from the fresh decode, not the latch
                if (wb_ack) begin
                    if (instr_dec == INS_HLT) begin
                        state_d = ST_HALT;
                    end else begin
                        state_d = ST_FETCH_ADR;
                    end
                end
            end
            ST_FETCH_ADR: begin
                if (wb_ack) begin
                    state_d = ST_EXEC;
                end
            end
            ST_EXEC: begin
                if (wb_ack) begin
                    state_d = ST_FETCH_OP;
                end
            end
            // sticky until reset
            ST_HALT: begin
                state_d = ST_HALT;
            end
            default: begin
                state_d = ST_HALT;
            end
        endcase
    end

    // three states own the bus
    assign busy = (state_q == ST_FETCH_OP) || (state_q == ST_FETCH_ADR) ||
                  (state_q == ST_EXEC);

    // both instruction words come from pc
    assign is_fetch = (state_q == ST_FETCH_OP) || (state_q == ST_FETCH_ADR);

    // cyc and stb move together, held through the ack cycle
    assign wb_cyc = busy;
    assign wb_stb = busy;

    // execute of STA is the only write
    assign wb_we = (state_q == ST_EXEC) && (instr_q == INS_STA);

    assign adr_sel_pc = is_fetch;
    assign pc_inc     = is_fetch && wb_ack;
    assign adr_load   = (state_q == ST_FETCH_ADR) && wb_ack;

    // accumulator written on the execute read of LDA or ADD
    assign acc_load = (state_q == ST_EXEC) && wb_ack &&
                      ((instr_q == INS_LDA) || (instr_q == INS_ADD));
    assign acc_add  = (state_q == ST_EXEC) && (instr_q == INS_ADD);

    assign halted = (state_q == ST_HALT);

endmodule

/* rtl/simpleton_datapath.sv */
`timescale 1ns/1ps

module simpleton_datapath #(
    parameter int DATA_W = simpleton_pkg::DATA_W_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,

    // enables and selects from the control unit
    input  logic              pc_inc,
    input  logic              adr_load,
    input  logic              acc_load,
    input  logic              acc_add,
    input  logic              adr_sel_pc,

    // bus data coming back from memory
    input  logic [DATA_W-1:0] wb_dat_r,

    // bus address and write data toward memory
    output logic [DATA_W-1:0] wb_adr,
    output logic [DATA_W-1:0] wb_dat_w,

    // status
    output logic [DATA_W-1:0] acc,
    output logic [DATA_W-1:0] pc
);

    // operand address register, loaded from the second instruction word
    logic [DATA_W-1:0] adr_q;

    // adder output, wraps at the word width
    logic [DATA_W-1:0] sum;

    // value headed for the accumulator
    logic [DATA_W-1:0] acc_d;

    // carry out is dropped on purpose
    assign sum = acc + wb_dat_r;

    // add for ADD, straight load for LDA
    assign acc_d = acc_add ? sum : wb_dat_r;

    // program counter
    // steps once per acknowledged fetch, opcode and operand alike
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    // operand address register
    always_ff @(posedge clk) begin
        if (rst) begin
            adr_q <= '0;
        end else if (adr_load) begin
            adr_q <= wb_dat_r;
        end
    end

    // accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (acc_load) begin
            acc <= acc_d;
        end
    end

    // address mux
    // fetches go out on pc, execute accesses on the operand address
    always_comb begin
        if (adr_sel_pc) begin
            wb_adr = pc;
        end else begin
            wb_adr = adr_q;
        end
    end

    // only STA writes, and it always writes the accumulator
    assign wb_dat_w = acc;

endmodule

/* rtl/simpleton_memory.sv */
`timescale 1ns/1ps

module simpleton_memory #(
    parameter int DATA_W = simpleton_pkg::DATA_W_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,

    // wishbone classic slave
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [DATA_W-1:0] wb_adr,
    input  logic [DATA_W-1:0] wb_dat_w,
    output logic [DATA_W-1:0] wb_dat_r,
    output logic              wb_ack,

    // load port, used while the core sits idle
    input  logic              load_we,
    input  logic [DATA_W-1:0] load_addr,
    input  logic [DATA_W-1:0] load_wdata,
    output logic [DATA_W-1:0] load_rdata
);

    // one word per address value
    localparam int DEPTH = 1 << DATA_W;

    logic [DATA_W-1:0] mem [DEPTH];

    // new request seen, not yet answered
    logic req_new;

    assign req_new = wb_cyc && wb_stb && !wb_ack;

    // ack pulses one cycle after stb is first sampled
    // dropping it again forces a fresh request for the next access
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req_new;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (req_new && !wb_we) begin
            wb_dat_r <= mem[wb_adr];
        end
    end

    // array writes
    // load port first, bus write lands at the end of the ack cycle
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_wdata;
        end
        if (wb_cyc && wb_stb && wb_we && wb_ack) begin
            mem[wb_adr] <= wb_dat_w;
        end
    end

    // asynchronous readback for the outside world
    assign load_rdata = mem[load_addr];

endmodule

/* rtl/simpleton_pkg.sv */
package simpleton_pkg;

    // default word and address width of the core
    localparam int DATA_W_DEFAULT = 8;

    // opcode field sits in the upper bits of an opcode word
    localparam int OPC_W = 4;

    // raw opcodes as they appear in memory
    typedef enum logic [OPC_W-1:0] {
        OPC_STA = 4'd1,
        OPC_LDA = 4'd2,
        OPC_ADD = 4'd3,
        OPC_HLT = 4'd15
    } opcode_t;

    // decoded instruction held by the control unit
    typedef enum logic [1:0] {
        INS_HLT,
        INS_STA,
        INS_LDA,
        INS_ADD
    } instr_t;

    // control FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH_OP,
        ST_FETCH_ADR,
        ST_EXEC,
        ST_HALT
    } state_t;

    // map an opcode nibble to the decoded instruction
    // anything undefined falls back to halt
    function automatic instr_t decode_opcode(input logic [OPC_W-1:0] opc);
        case (opc)
            OPC_STA: return INS_STA;
            OPC_LDA: return INS_LDA;
            OPC_ADD: return INS_ADD;
            default: return INS_HLT;
        endcase
    endfunction

endpackage

/* rtl/simpleton_top.sv */
`timescale 1ns/1ps

module simpleton_top #(
    parameter int DATA_W = simpleton_pkg::DATA_W_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,

    // memory load port
    input  logic              load_we,
    input  logic [DATA_W-1:0] load_addr,
    input  logic [DATA_W-1:0] load_wdata,
    output logic [DATA_W-1:0] load_rdata,

    // status
    output logic [DATA_W-1:0] acc,
    output logic [DATA_W-1:0] pc,
    output logic              halted
);

    import simpleton_pkg::*;

    // wishbone between core and memory
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [DATA_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;

    // control to datapath
    logic              pc_inc;
    logic              adr_load;
    logic              acc_load;
    logic              acc_add;
    logic              adr_sel_pc;

    simpleton_control i_control (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .wb_ack     (wb_ack),
        // opcode nibble straight off the read bus
        .wb_opcode  (wb_dat_r[DATA_W-1 -: OPC_W]),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .pc_inc     (pc_inc),
        .adr_load   (adr_load),
        .acc_load   (acc_load),
        .acc_add    (acc_add),
        .adr_sel_pc (adr_sel_pc),
        .halted     (halted)
    );

    simpleton_datapath #(
        .DATA_W (DATA_W)
    ) i_datapath (
        .clk        (clk),
        .rst        (rst),
        .pc_inc     (pc_inc),
        .adr_load   (adr_load),
        .acc_load   (acc_load),
        .acc_add    (acc_add),
        .adr_sel_pc (adr_sel_pc),
        .wb_dat_r   (wb_dat_r),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .acc        (acc),
        .pc         (pc)
    );

    simpleton_memory #(
        .DATA_W (DATA_W)
    ) i_memory (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_wdata (load_wdata),
        .load_rdata (load_rdata)
    );

endmodule
